// ==== Bender.yml ====
package:
  name: sdmac

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sdmac_pkg.sv
      - verilog/sdmac_regs.sv
      - verilog/word_fifo.sv
      - verilog/halfword_packer.sv
      - verilog/dma_ctrl.sv
      - verilog/sdmac_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/sdmac_tb_models.sv
      - dv/sdmac_tb.sv

// ==== dv/sdmac_tb.sv ====
// Testbench for the SCSI DMA controller core
// Register readback, both transfer directions, back-pressure, flush and
// interrupt pass-through, with bus and strobe rules checked every cycle

`timescale 1ns/1ps
`include "sdmac_macros.svh"

module sdmac_tb;

    import sdmac_pkg::*;

    localparam int HALVES  = 2 * `SDMAC_FIFO_DEPTH; // One FIFO load of halfwords
    localparam int TIMEOUT = 4000;                  // Twice the longest run

    logic        sclk;
    logic        reset;
    logic        cs;
    logic        rw;
    logic [2:0]  addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        bg;
    logic        dsack;
    logic [31:0] din;
    logic [31:0] dout;
    logic        dreq;
    logic        inta;
    logic [15:0] pd_in;
    logic [15:0] pd_out;
    logic        int_out;
    host_bus_o_t host_bus;
    periph_o_t   periph_bus;
    logic [31:0] rng;
    logic [15:0] halves [32];
    logic [31:0] words [`SDMAC_FIFO_DEPTH];
    int          cycles;

    sdmac_top sdmac_top_i (
        .sclk_i   (sclk),
        .reset_i  (reset),
        .cs_i     (cs),
        .rw_i     (rw),
        .addr_i   (addr),
        .wdata_i  (wdata),
        .rdata_o  (rdata),
        .bg_i     (bg),
        .dsack_i  (dsack),
        .din_i    (din),
        .host_o   (host_bus),
        .dout_o   (dout),
        .dreq_i   (dreq),
        .inta_i   (inta),
        .pd_i     (pd_in),
        .periph_o (periph_bus),
        .pd_o     (pd_out),
        .int_o    (int_out)
    );

    host_mem_model host_i (
        .clk_i   (sclk),
        .br_i    (host_bus.br),
        .as_i    (host_bus.as),
        .rw_i    (host_bus.rw),
        .dout_i  (dout),
        .bg_o    (bg),
        .dsack_o (dsack),
        .din_o   (din)
    );

    scsi_periph_model periph_i (
        .clk_i  (sclk),
        .ior_i  (periph_bus.ior),
        .iow_i  (periph_bus.iow),
        .pd_i   (pd_out),
        .dreq_o (dreq),
        .pd_o   (pd_in)
    );

    always #20 sclk = ~sclk;

    always @(posedge sclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s expected %h actual %h", name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1, "Check %s failed", name);
    endtask

    // Bus ownership and strobe rules
    assert property (@(posedge sclk) disable iff (reset) host_bus.as |-> host_bus.own)
        else report_mismatch("as_needs_own", 32'd1, host_bus.own);
    assert property (@(posedge sclk) disable iff (reset) host_bus.own |-> bg)
        else report_mismatch("own_needs_grant", 32'd1, bg);
    assert property (@(posedge sclk) disable iff (reset) host_bus.dma_en == host_bus.own)
        else report_mismatch("dma_en_with_own", host_bus.own, host_bus.dma_en);
    assert property (@(posedge sclk) disable iff (reset) !(periph_bus.ior && periph_bus.iow))
        else report_mismatch("ior_iow_exclusive", 32'd0, {periph_bus.ior, periph_bus.iow});
    assert property (@(posedge sclk) disable iff (reset)
                     (periph_bus.ior || periph_bus.iow) |-> periph_bus.dack)
        else report_mismatch("strobe_needs_dack", 32'd1, periph_bus.dack);
    assert property (@(posedge sclk) disable iff (reset) !periph_bus.css)
        else report_mismatch("css_low", 32'd0, periph_bus.css);
    assert property (@(posedge sclk) disable iff (reset) (host_bus.as && !dsack) |=> host_bus.as)
        else report_mismatch("as_held_until_dsack", 32'd1, host_bus.as);

    task automatic reg_write(input logic [2:0] a, input logic [31:0] d);
        @(negedge sclk);
        cs    = 1'b1;
        rw    = 1'b0;
        addr  = a;
        wdata = d;
        @(negedge sclk);
        cs = 1'b0;
    endtask

    task automatic reg_read(input logic [2:0] a, output logic [31:0] d);
        @(negedge sclk);
        cs   = 1'b1;
        rw   = 1'b1;
        addr = a;
        @(negedge sclk);
        cs = 1'b0;
        d  = rdata;
    endtask

    task automatic start_dma();
        reg_write(`SDMAC_ADDR_ST_DMA, 32'd0);
        @(negedge sclk); // FIFO clear lands one cycle after the strobe
    endtask

    task automatic wait_bus_idle();
        while (host_bus.br) @(negedge sclk);
    endtask

    task automatic check_int(input string name, input logic expected);
        @(negedge sclk);
        assert (int_out == expected) else report_mismatch(name, expected, int_out);
    endtask

    // Fresh peripheral data and host delays, then a P2M run until n halfwords are in
    task automatic run_p2m(input int n, input int max_delay, input logic [2:0] contr);
        reg_write(`SDMAC_ADDR_CONTR, 32'd0);
        start_dma();
        for (int i = 0; i < 32; i++) begin
            rng = xorshift32(rng);
            halves[i] = rng[15:0];
            periph_i.src_q[i] = rng[15:0];
        end
        for (int i = 0; i < 16; i++) begin
            rng = xorshift32(rng);
            host_i.delay_q[i] = rng % (max_delay + 1);
        end
        host_i.rewind();
        periph_i.arm(n);
        reg_write(`SDMAC_ADDR_CONTR, {29'd0, contr});
        while (periph_i.count < n || host_i.wr_cnt < n / 2) @(negedge sclk);
    endtask

    // Big-endian packing, an odd last halfword gets a zero low half
    task automatic check_host_words(input string name, input int n);
        logic [31:0] expected;
        assert (host_i.wr_cnt == (n + 1) / 2)
            else report_mismatch({name, "_count"}, (n + 1) / 2, host_i.wr_cnt);
        for (int j = 0; j < (n + 1) / 2; j++) begin
            expected = {halves[2*j], (2*j + 1 < n) ? halves[2*j + 1] : 16'h0000};
            assert (host_i.mem_q[j] == expected)
                else report_mismatch(name, expected, host_i.mem_q[j]);
        end
    endtask

    initial begin
        logic [31:0] value;
        logic [15:0] half_exp;
        istr_t       status;
        sclk   = 1'b0;
        reset  = 1'b1;
        cs     = 1'b0;
        rw     = 1'b0;
        addr   = 3'd0;
        wdata  = 32'd0;
        inta   = 1'b0;
        rng    = 32'd73548;
        cycles = 0;
        repeat (16) @(negedge sclk);
        reset = 1'b0;
        @(negedge sclk);
        value = {host_bus.br, host_bus.own, host_bus.as, host_bus.dma_en,
                 periph_bus.dack, periph_bus.ior, periph_bus.iow, int_out};
        assert (value == 32'd0) else report_mismatch("reset_outputs", 32'd0, value);

        // Register readback
        for (int v = 0; v < 8; v++) begin
            reg_write(`SDMAC_ADDR_CONTR, v);
            reg_read(`SDMAC_ADDR_CONTR, value);
            assert (value == v) else report_mismatch("contr_readback", v, value);
        end
        reg_write(`SDMAC_ADDR_CONTR, 32'd4); // Stop, direction kept
        wait_bus_idle();
        reg_write(`SDMAC_ADDR_CONTR, 32'd0);
        start_dma();
        reg_read(`SDMAC_ADDR_ISTR, value);
        status = istr_t'(value[4:0]);
        assert (status.fifo_empty) else report_mismatch("istr_fifo_empty", 32'd1, value);

        run_p2m(HALVES, 0, 3'b010);
        reg_write(`SDMAC_ADDR_CONTR, 32'd0);
        wait_bus_idle();
        check_host_words("p2m_transfer", HALVES);

        // Memory to peripheral
        reg_write(`SDMAC_ADDR_CONTR, 32'd4);
        start_dma();
        for (int j = 0; j < `SDMAC_FIFO_DEPTH; j++) begin
            rng = xorshift32(rng);
            words[j] = rng;
            host_i.mem_q[j] = rng;
        end
        for (int i = 0; i < 16; i++) host_i.delay_q[i] = 0;
        host_i.rewind();
        periph_i.arm(HALVES);
        reg_write(`SDMAC_ADDR_CONTR, 32'd6);
        while (periph_i.count < HALVES) @(negedge sclk);
        reg_write(`SDMAC_ADDR_CONTR, 32'd4);
        wait_bus_idle();
        for (int i = 0; i < HALVES; i++) begin
            half_exp = (i % 2 == 1) ? words[i / 2][15:0] : words[i / 2][31:16];
            assert (periph_i.sink_q[i] == half_exp)
                else report_mismatch("m2p_transfer", half_exp, periph_i.sink_q[i]);
        end

        run_p2m(HALVES, 6, 3'b010); // Slow host acknowledge
        reg_write(`SDMAC_ADDR_CONTR, 32'd0);
        wait_bus_idle();
        check_host_words("back_pressure", HALVES);

        // Flush after an odd halfword count
        run_p2m(5, 2, 3'b011);
        reg_write(`SDMAC_ADDR_FLUSH, 32'd0);
        status = '0;
        while (!status.flush_done) begin
            reg_read(`SDMAC_ADDR_ISTR, value);
            status = istr_t'(value[4:0]);
        end
        check_host_words("flush_padding", 5);
        assert (int_out) else report_mismatch("flush_interrupt", 32'd1, int_out);
        reg_write(`SDMAC_ADDR_CINT, 32'd0);
        reg_read(`SDMAC_ADDR_ISTR, value);
        status = istr_t'(value[4:0]);
        assert (!status.flush_done && !int_out)
            else report_mismatch("cint_clear", 32'd0, {status.flush_done, int_out});
        reg_write(`SDMAC_ADDR_CONTR, 32'd0);

        // Interrupt pass-through
        inta = 1'b1;
        check_int("int_masked", 1'b0);
        reg_write(`SDMAC_ADDR_CONTR, 32'd1);
        check_int("int_enabled", 1'b1);
        inta = 1'b0;
        check_int("int_follows_low", 1'b0);
        inta = 1'b1;
        check_int("int_follows_high", 1'b1);
        reg_write(`SDMAC_ADDR_CONTR, 32'd0);
        check_int("int_disabled", 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== dv/sdmac_tb_models.sv ====
// Behavioral models around the SCSI DMA controller core
// Host memory that grants the bus and answers each strobe after a set delay,
// and a SCSI peripheral that requests a set number of halfword cycles

`timescale 1ns/1ps

module host_mem_model (
    input  logic        clk_i,
    input  logic        br_i,
    input  logic        as_i,
    input  logic        rw_i,
    input  logic [31:0] dout_i,
    output logic        bg_o,
    output logic        dsack_o,
    output logic [31:0] din_o
);

    logic [31:0] mem_q [16];
    int          delay_q [16]; // Wait cycles before each acknowledge
    int          wr_cnt;
    int          rd_cnt;
    int          wait_cnt;

    initial begin
        bg_o    = 1'b0;
        dsack_o = 1'b0;
        din_o   = 32'd0;
        for (int i = 0; i < 16; i++) begin
            mem_q[i]   = 32'd0;
            delay_q[i] = 0;
        end
        rewind();
    end

    task automatic rewind();
        wr_cnt   = 0;
        rd_cnt   = 0;
        wait_cnt = 0;
    endtask

    always @(negedge clk_i) begin
        bg_o <= br_i; // Grant follows request
        if (dsack_o) begin
            dsack_o <= 1'b0;
        end else if (as_i) begin
            if (wait_cnt < delay_q[(wr_cnt + rd_cnt) % 16]) begin
                wait_cnt <= wait_cnt + 1;
            end else begin
                wait_cnt <= 0;
                dsack_o  <= 1'b1;
                if (rw_i) begin
                    din_o  <= mem_q[rd_cnt % 16];
                    rd_cnt <= rd_cnt + 1;
                end else begin
                    mem_q[wr_cnt % 16] <= dout_i;
                    wr_cnt <= wr_cnt + 1;
                end
            end
        end
    end

endmodule

module scsi_periph_model (
    input  logic        clk_i,
    input  logic        ior_i,
    input  logic        iow_i,
    input  logic [15:0] pd_i,
    output logic        dreq_o,
    output logic [15:0] pd_o
);

    logic [15:0] src_q [32];  // Halfwords sent to the core
    logic [15:0] sink_q [32]; // Halfwords written by the core
    logic [15:0] wr_latch;
    logic        strobe_d;
    logic        iow_d;
    int          limit;
    int          count;

    initial begin
        dreq_o   = 1'b0;
        pd_o     = 16'd0;
        wr_latch = 16'd0;
        strobe_d = 1'b0;
        iow_d    = 1'b0;
        limit    = 0;
        count    = 0;
    end

    // Requests n halfword cycles starting from src_q[0]
    task automatic arm(input int n);
        limit  = n;
        count  = 0;
        pd_o   = src_q[0];
        dreq_o = (n > 0);
    endtask

    always @(negedge clk_i) begin
        strobe_d <= ior_i || iow_i;
        iow_d    <= iow_i;
        if (iow_i) wr_latch <= pd_i;
        // A cycle ends when the strobe falls
        if (strobe_d && !(ior_i || iow_i)) begin
            if (iow_d) sink_q[count % 32] <= wr_latch;
            count  <= count + 1;
            pd_o   <= src_q[(count + 1) % 32];
            dreq_o <= (count + 1 < limit);
        end
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/sdmac_pkg.sv
verilog/sdmac_regs.sv
verilog/word_fifo.sv
verilog/halfword_packer.sv
verilog/dma_ctrl.sv
verilog/sdmac_top.sv
dv/sdmac_tb_models.sv
dv/sdmac_tb.sv

// ==== verilog/dma_ctrl.sv ====
// DMA control for the SCSI DMA core
// Peripheral cycle sequencer, host bus master sequencer and flush sequence.
// Peripheral cycle is two strobe cycles plus one recovery cycle

`timescale 1ns/1ps

module dma_ctrl (
    input  logic                   sclk_i,
    input  logic                   reset_i,
    input  sdmac_pkg::contr_t      contr_i,
    input  logic                   start_i,
    input  logic                   flush_i,
    input  logic                   dreq_i,
    input  logic                   bg_i,
    input  logic                   dsack_i,
    input  logic                   fifo_full_i,
    input  logic                   fifo_empty_i,
    input  logic                   word_valid_i,
    input  logic                   half_pending_i,
    output sdmac_pkg::host_bus_o_t host_o,
    output sdmac_pkg::periph_o_t   periph_o,
    output logic                   load_half_o,
    output logic                   take_half_o,
    output logic                   pad_o,
    output logic                   push_o,
    output logic                   pop_o,
    output logic                   clear_o,
    output logic                   flush_done_o
);

    typedef enum logic [1:0] {P_IDLE, P_STROBE, P_RECOVER} p_state_e;
    typedef enum logic [1:0] {B_IDLE, B_REQ, B_STROBE, B_GAP} b_state_e;
    typedef enum logic [1:0] {F_IDLE, F_PAD, F_DRAIN} f_state_e;

    p_state_e p_state_q;
    b_state_e b_state_q;
    f_state_e f_state_q;
    logic     strobe_cnt_q;
    logic     m2p;
    logic     active;
    logic     can_serve;
    logic     strobe_last;
    logic     want_bus;
    logic     bus_done;
    logic     host_take;
    logic     drained;

    assign m2p         = contr_i.dma_dir;
    assign active      = contr_i.dma_ena || (f_state_q != F_IDLE);
    assign can_serve   = m2p ? !fifo_empty_i : !fifo_full_i;
    assign strobe_last = (p_state_q == P_STROBE) && strobe_cnt_q;

    // Peripheral cycle sequencer
    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            p_state_q    <= P_IDLE;
            strobe_cnt_q <= 1'b0;
        end else begin
            case (p_state_q)
                P_IDLE: begin
                    strobe_cnt_q <= 1'b0;
                    if (dreq_i && contr_i.dma_ena && can_serve && (f_state_q == F_IDLE)) begin
                        p_state_q <= P_STROBE;
                    end
                end
                P_STROBE: begin
                    strobe_cnt_q <= 1'b1;
                    if (strobe_cnt_q) p_state_q <= P_RECOVER;
                end
                default: p_state_q <= P_IDLE;
            endcase
        end
    end

    // Memory to peripheral refills only from empty, in bursts
    assign want_bus  = active && (m2p ? fifo_empty_i : !fifo_empty_i);
    assign bus_done  = !active || (m2p ? fifo_full_i : fifo_empty_i);
    assign host_take = (b_state_q == B_STROBE) && dsack_i;

    // Bus master sequencer, GAP also serves as the owned cycle before the first strobe
    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            b_state_q <= B_IDLE;
        end else begin
            case (b_state_q)
                B_IDLE:   if (want_bus) b_state_q <= B_REQ;
                B_REQ:    if (bg_i) b_state_q <= B_GAP;
                B_GAP:    b_state_q <= bus_done ? B_IDLE : B_STROBE;
                B_STROBE: if (dsack_i) b_state_q <= B_GAP; // as held until acknowledge
                default:  b_state_q <= B_IDLE;
            endcase
        end
    end

    // Flush waits for the peripheral cycle, pads, then drains to the host
    assign drained = fifo_empty_i && !word_valid_i && (b_state_q == B_IDLE);

    always_ff @(posedge sclk_i) begin
        if (reset_i || start_i) begin
            f_state_q <= F_IDLE;
        end else begin
            case (f_state_q)
                F_IDLE:  if (flush_i && !m2p) f_state_q <= F_PAD;
                F_PAD:   if (p_state_q == P_IDLE) f_state_q <= F_DRAIN;
                F_DRAIN: if (drained) f_state_q <= F_IDLE;
                default: f_state_q <= F_IDLE;
            endcase
        end
    end

    assign host_o.br     = (b_state_q != B_IDLE);
    assign host_o.own    = (b_state_q == B_GAP) || (b_state_q == B_STROBE);
    assign host_o.as     = (b_state_q == B_STROBE);
    assign host_o.rw     = host_o.own && m2p;
    assign host_o.dma_en = host_o.own;

    assign periph_o.dack = (p_state_q == P_STROBE);
    assign periph_o.ior  = (p_state_q == P_STROBE) && !m2p;
    assign periph_o.iow  = (p_state_q == P_STROBE) && m2p;
    assign periph_o.css  = 1'b0; // Chip registers are not reached through this core

    assign load_half_o  = strobe_last && !m2p; // pd_i sampled at end of ior
    assign take_half_o  = strobe_last && m2p;
    assign pad_o        = (f_state_q == F_PAD) && (p_state_q == P_IDLE) && half_pending_i;
    assign push_o       = m2p ? host_take : word_valid_i;
    assign pop_o        = m2p ? (take_half_o && half_pending_i) : host_take;
    assign clear_o      = start_i;
    assign flush_done_o = (f_state_q == F_DRAIN) && drained;

endmodule

// ==== verilog/halfword_packer.sv ====
// Halfword packer between the 16-bit peripheral port and the FIFO
// Receive: collects hi then lo into a holding word, pulses word_valid_o
// Send: presents hi then lo of the FIFO head word on pd_o

`timescale 1ns/1ps

module halfword_packer (
    input  logic                  sclk_i,
    input  logic                  reset_i,
    input  logic                  dir_i,
    input  logic                  load_half_i,
    input  logic                  take_half_i,
    input  logic                  pad_i,
    input  logic [15:0]           pd_i,
    input  sdmac_pkg::fifo_word_u fifo_word_i,
    output logic [15:0]           pd_o,
    output sdmac_pkg::fifo_word_u word_o,
    output logic                  word_valid_o,
    output logic                  half_pending_o
);

    import sdmac_pkg::*;

    fifo_word_u hold_q;
    logic       half_q;  // Receive: hi is held. Send: hi already sent
    logic       valid_q;
    logic       rx_load;
    logic       rx_pad;
    logic       tx_take;

    assign rx_load = load_half_i && !dir_i;
    assign rx_pad  = pad_i && !dir_i && half_q; // Only a lone hi half gets padded
    assign tx_take = take_half_i && dir_i;

    // Holding word
    always_ff @(posedge sclk_i) begin
        if (rx_load) begin
            if (half_q) begin
                hold_q.half.lo <= pd_i;
            end else begin
                hold_q.half.hi <= pd_i;
            end
        end else if (rx_pad) begin
            hold_q.half.lo <= 16'h0000;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            half_q  <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= (rx_load && half_q) || rx_pad; // Word complete at this edge
            if (rx_pad) begin
                half_q <= 1'b0;
            end else if (rx_load || tx_take) begin
                half_q <= !half_q;
            end
        end
    end

    assign pd_o           = half_q ? fifo_word_i.half.lo : fifo_word_i.half.hi;
    assign word_o         = hold_q;
    assign word_valid_o   = valid_q;
    assign half_pending_o = half_q;

endmodule

// ==== verilog/sdmac_macros.svh ====
// SCSI DMA controller constants
// FIFO depth and host register word indexes

`ifndef SDMAC_MACROS_SVH
`define SDMAC_MACROS_SVH

// Number of 32-bit words held in the transfer FIFO
`define SDMAC_FIFO_DEPTH 8

// Host register word indexes on addr_i
`define SDMAC_ADDR_CONTR  3'd0 // Control, read and write
`define SDMAC_ADDR_ISTR   3'd1 // Status, read only
`define SDMAC_ADDR_ST_DMA 3'd2 // Start DMA command, write only
`define SDMAC_ADDR_FLUSH  3'd3 // Flush command, write only
`define SDMAC_ADDR_CINT   3'd4 // Clear interrupt command, write only

`endif

// ==== verilog/sdmac_pkg.sv ====
// SCSI DMA controller types
// Register layouts, output bus groups and the FIFO word

package sdmac_pkg;

    // Control register, bit 2 down to bit 0
    typedef struct packed {
        logic dma_dir; // 1 moves memory to peripheral
        logic dma_ena;
        logic int_ena;
    } contr_t;

    // Status register, bit 4 down to bit 0
    typedef struct packed {
        logic int_pending;
        logic inta;
        logic fifo_empty;
        logic fifo_full;
        logic flush_done;
    } istr_t;

    // Host bus master outputs
    typedef struct packed {
        logic br;     // Bus request
        logic own;    // Core is bus master
        logic as;     // Address strobe
        logic rw;     // 1 reads from memory
        logic dma_en; // Enables the external address generator
    } host_bus_o_t;

    // Peripheral control outputs
    typedef struct packed {
        logic dack;
        logic ior;
        logic iow;
        logic css;
    } periph_o_t;

    // Big-endian halfword pair, first peripheral halfword in hi
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } halfword_pair_t;

    // One FIFO entry seen from the host side or from the peripheral side
    typedef union packed {
        logic [31:0]    word;
        halfword_pair_t half;
    } fifo_word_u;

endpackage

// ==== verilog/sdmac_regs.sv ====
// SCSI DMA controller register file
// Holds CONTR and the sticky flush_done flag, turns command writes into
// single-cycle strobes, returns CONTR or ISTR on reads and forms int_o

`timescale 1ns/1ps
`include "sdmac_macros.svh"

module sdmac_regs (
    input  logic              sclk_i,
    input  logic              reset_i,
    input  logic              cs_i,
    input  logic              rw_i,
    input  logic [2:0]        addr_i,
    input  logic [31:0]       wdata_i,
    input  logic              inta_i,
    input  logic              fifo_empty_i,
    input  logic              fifo_full_i,
    input  logic              flush_done_i,
    output logic [31:0]       rdata_o,
    output sdmac_pkg::contr_t contr_o,
    output logic              start_o,
    output logic              flush_o,
    output logic              int_o
);

    import sdmac_pkg::*;

    contr_t contr_q;
    istr_t  istr;
    logic   flush_done_q;
    logic   wr_en;
    logic   rd_en;

    assign wr_en = cs_i && !rw_i;
    assign rd_en = cs_i && rw_i;

    always_ff @(posedge sclk_i) begin
        if (reset_i) begin
            contr_q      <= '0;
            flush_done_q <= 1'b0;
            start_o      <= 1'b0;
            flush_o      <= 1'b0;
        end else begin
            start_o <= wr_en && (addr_i == `SDMAC_ADDR_ST_DMA);
            flush_o <= wr_en && (addr_i == `SDMAC_ADDR_FLUSH);
            if (wr_en && (addr_i == `SDMAC_ADDR_CONTR)) begin
                contr_q <= contr_t'(wdata_i[2:0]);
            end
            // A completing flush wins over a CINT in the same cycle
            if (flush_done_i) begin
                flush_done_q <= 1'b1;
            end else if (wr_en && (addr_i == `SDMAC_ADDR_CINT)) begin
                flush_done_q <= 1'b0;
            end
        end
    end

    assign int_o   = contr_q.int_ena && (inta_i || flush_done_q);
    assign contr_o = contr_q;

    always_comb begin
        istr.int_pending = int_o;
        istr.inta        = inta_i;
        istr.fifo_empty  = fifo_empty_i;
        istr.fifo_full   = fifo_full_i;
        istr.flush_done  = flush_done_q;
    end

    // Read data is captured on the strobe and held until the next read
    always_ff @(posedge sclk_i) begin
        if (rd_en) begin
            case (addr_i)
                `SDMAC_ADDR_CONTR: rdata_o <= {29'd0, contr_q};
                `SDMAC_ADDR_ISTR:  rdata_o <= {27'd0, istr};
                default:           rdata_o <= 32'd0; // Command registers read as zero
            endcase
        end
    end

endmodule

// ==== verilog/sdmac_top.sv ====
// SCSI DMA controller core top level
// Register file, DMA control, word FIFO and halfword packer between a
// 32-bit host bus and a 16-bit SCSI peripheral port

`timescale 1ns/1ps

module sdmac_top (
    input  logic                   sclk_i,
    input  logic                   reset_i,
    input  logic                   cs_i,
    input  logic                   rw_i,
    input  logic [2:0]             addr_i,
    input  logic [31:0]            wdata_i,
    output logic [31:0]            rdata_o,
    input  logic                   bg_i,
    input  logic                   dsack_i,
    input  logic [31:0]            din_i,
    output sdmac_pkg::host_bus_o_t host_o,
    output logic [31:0]            dout_o,
    input  logic                   dreq_i,
    input  logic                   inta_i,
    input  logic [15:0]            pd_i,
    output sdmac_pkg::periph_o_t   periph_o,
    output logic [15:0]            pd_o,
    output logic                   int_o
);

    import sdmac_pkg::*;

    contr_t     contr;
    fifo_word_u fifo_wdata;
    fifo_word_u fifo_rdata;
    fifo_word_u packer_word;
    logic       start;
    logic       flush;
    logic       flush_done;
    logic       fifo_full;
    logic       fifo_empty;
    logic       word_valid;
    logic       half_pending;
    logic       load_half;
    logic       take_half;
    logic       pad;
    logic       push;
    logic       pop;
    logic       clear;

    // FIFO is filled from the host bus or from the packer
    always_comb begin
        if (contr.dma_dir) begin
            fifo_wdata.word = din_i;
        end else begin
            fifo_wdata = packer_word;
        end
    end

    assign dout_o = fifo_rdata.word;

    sdmac_regs sdmac_regs_i (
        .sclk_i       (sclk_i),
        .reset_i      (reset_i),
        .cs_i         (cs_i),
        .rw_i         (rw_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .inta_i       (inta_i),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .flush_done_i (flush_done),
        .rdata_o      (rdata_o),
        .contr_o      (contr),
        .start_o      (start),
        .flush_o      (flush),
        .int_o        (int_o)
    );

    dma_ctrl dma_ctrl_i (
        .sclk_i         (sclk_i),
        .reset_i        (reset_i),
        .contr_i        (contr),
        .start_i        (start),
        .flush_i        (flush),
        .dreq_i         (dreq_i),
        .bg_i           (bg_i),
        .dsack_i        (dsack_i),
        .fifo_full_i    (fifo_full),
        .fifo_empty_i   (fifo_empty),
        .word_valid_i   (word_valid),
        .half_pending_i (half_pending),
        .host_o         (host_o),
        .periph_o       (periph_o),
        .load_half_o    (load_half),
        .take_half_o    (take_half),
        .pad_o          (pad),
        .push_o         (push),
        .pop_o          (pop),
        .clear_o        (clear),
        .flush_done_o   (flush_done)
    );

    word_fifo word_fifo_i (
        .sclk_i  (sclk_i),
        .reset_i (reset_i),
        .push_i  (push),
        .pop_i   (pop),
        .clear_i (clear),
        .wdata_i (fifo_wdata),
        .rdata_o (fifo_rdata),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    halfword_packer halfword_packer_i (
        .sclk_i         (sclk_i),
        .reset_i        (reset_i),
        .dir_i          (contr.dma_dir),
        .load_half_i    (load_half),
        .take_half_i    (take_half),
        .pad_i          (pad),
        .pd_i           (pd_i),
        .fifo_word_i    (fifo_rdata),
        .pd_o           (pd_o),
        .word_o         (packer_word),
        .word_valid_o   (word_valid),
        .half_pending_o (half_pending)
    );

endmodule

// ==== verilog/word_fifo.sv ====
// Transfer FIFO of 32-bit words
// Circular buffer with occupancy count, head word shown combinationally

`timescale 1ns/1ps
`include "sdmac_macros.svh"

module word_fifo (
    input  logic                  sclk_i,
    input  logic                  reset_i,
    input  logic                  push_i,
    input  logic                  pop_i,
    input  logic                  clear_i,
    input  sdmac_pkg::fifo_word_u wdata_i,
    output sdmac_pkg::fifo_word_u rdata_o,
    output logic                  full_o,
    output logic                  empty_o
);

    import sdmac_pkg::*;

    localparam int DEPTH = `SDMAC_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam logic [AW:0] FULL_CNT = (AW+1)'(DEPTH);

    fifo_word_u    mem_q [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [AW:0]   count_q;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i && !full_o;  // Pushes into a full FIFO are dropped
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge sclk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (reset_i || clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign rdata_o = mem_q[rd_ptr_q];
    assign full_o  = (count_q == FULL_CNT);
    assign empty_o = (count_q == '0);

endmodule
